/* switch_pkg.sv */
// switch_pkg package: port count, port index, port mask, GMII byte and queue word types
package switch_pkg;

  // --------------------
  // port geometry
  // --------------------
  localparam int PORT_COUNT = 4;

  // index of one switch port
  typedef logic [$clog2(PORT_COUNT)-1:0] port_idx_t;

  // bit i stands for transmit port i
  typedef logic [PORT_COUNT-1:0] port_mask_t;

  // --------------------
  // data path words
  // --------------------
  typedef logic [7:0] gmii_byte_t;

  // bit 8 set: data byte in [7:0]
  // bit 8 clear: end of frame marker
  typedef logic [8:0] queue_word_t;

endpackage

/* cmd_pkg.sv */
// cmd_pkg package: command port, command magic byte and forwarding table type
package cmd_pkg;

  // frames on this port are parsed for commands
  localparam int CMD_PORT = switch_pkg::PORT_COUNT - 1;

  // first byte of a command frame
  localparam switch_pkg::gmii_byte_t CMD_MAGIC = 8'hC3;

  // entry i is the destination mask for frames from source i
  typedef switch_pkg::port_mask_t [switch_pkg::PORT_COUNT-1:0] fwd_table_t;

endpackage

/* frame_fifo.sv */
// frame_fifo module: synchronous show-ahead queue with occupancy count
`timescale 1ns/100ps

module frame_fifo #(
    parameter int QUEUE_AW = 8
) (
    input  logic                    sys_clk
  , input  logic                    reset
  , input  switch_pkg::queue_word_t din
  , input  logic                    wr_en
  , output switch_pkg::queue_word_t dout
  , output logic                    empty
  , input  logic                    rd_en
  , output logic [QUEUE_AW:0]       data_count
);

  localparam int DEPTH = 2 ** QUEUE_AW;

  switch_pkg::queue_word_t mem [DEPTH];
  logic [QUEUE_AW-1:0]     wr_ptr;
  logic [QUEUE_AW-1:0]     rd_ptr;
  logic                    do_wr;
  logic                    do_rd;

  // top count bit alone marks a full queue
  assign do_wr = wr_en && !data_count[QUEUE_AW];
  assign do_rd = rd_en && !empty;
  assign empty = (data_count == '0);

  // head word visible before the read strobe
  assign dout = mem[rd_ptr];

  always_ff @(posedge sys_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      data_count <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   data_count <= data_count + 1'b1;
        2'b01:   data_count <= data_count - 1'b1;
        default: data_count <= data_count;
      endcase
    end
  end

endmodule

/* cmd_recv.sv */
// cmd_recv module: command frame parser on the command port and forwarding table
`timescale 1ns/100ps

module cmd_recv (
    input  logic                   sys_clk
  , input  logic                   reset
  , input  switch_pkg::gmii_byte_t rxd
  , input  logic                   rx_dv
  , output cmd_pkg::fwd_table_t    fwd_table
  , output logic                   cmd_mode
);

  localparam switch_pkg::port_idx_t LAST_IDX =
    switch_pkg::port_idx_t'(switch_pkg::PORT_COUNT - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CHECK_MAGIC,
    ST_COLLECT,
    ST_SKIP_REST
  } cmd_state_t;

  cmd_state_t            state;
  switch_pkg::port_idx_t mask_idx;
  cmd_pkg::fwd_table_t   table_shadow;
  logic                  cmd_valid;

  // --------------------
  // parser FSM
  // --------------------
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      mask_idx  <= '0;
      cmd_valid <= 1'b0;
      fwd_table <= '0;
      cmd_mode  <= 1'b0;
    end else begin
      case (state)
        // wait out a frame that was running at reset release
        ST_IDLE: begin
          if (!rx_dv) begin
            state <= ST_CHECK_MAGIC;
          end
        end
        ST_CHECK_MAGIC: begin
          mask_idx  <= '0;
          cmd_valid <= 1'b0;
          if (rx_dv) begin
            state <= (rxd == cmd_pkg::CMD_MAGIC) ? ST_COLLECT : ST_SKIP_REST;
          end
        end
        ST_COLLECT: begin
          if (!rx_dv) begin
            // too short, table untouched
            state <= ST_CHECK_MAGIC;
          end else begin
            mask_idx <= mask_idx + 1'b1;
            if (mask_idx == LAST_IDX) begin
              cmd_valid <= 1'b1;
              state     <= ST_SKIP_REST;
            end
          end
        end
        ST_SKIP_REST: begin
          if (!rx_dv) begin
            state <= ST_CHECK_MAGIC;
            if (cmd_valid) begin
              fwd_table <= table_shadow;
              cmd_mode  <= 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // mask byte k after the magic is for source k-1
  always_ff @(posedge sys_clk) begin
    if (state == ST_COLLECT && rx_dv) begin
      table_shadow[mask_idx] <= rxd[switch_pkg::PORT_COUNT-1:0];
    end
  end

endmodule

/* rx_port.sv */
// rx_port module: frame intake, destination selection and per-destination queues
`timescale 1ns/100ps

module rx_port #(
    parameter int PORT_NUM  = 0
  , parameter int QUEUE_AW  = 8
  , parameter int MAX_FRAME = 64
) (
    input  logic                   sys_clk
  , input  logic                   reset
  , input  switch_pkg::gmii_byte_t rxd
  , input  logic                   rx_dv
  , input  cmd_pkg::fwd_table_t    fwd_table
  , input  logic                   cmd_mode
  , output switch_pkg::queue_word_t [switch_pkg::PORT_COUNT-1:0] q_dout
  , output switch_pkg::port_mask_t q_empty
  , input  switch_pkg::port_mask_t q_rd_en
);

  localparam int CW = $clog2(MAX_FRAME + 1);
  localparam logic [CW-1:0] MAX_CNT = CW'(MAX_FRAME);
  // highest count that still leaves room for a full frame and its marker
  localparam logic [QUEUE_AW:0] ROOM_LIMIT =
    (QUEUE_AW + 1)'(2 ** QUEUE_AW - MAX_FRAME - 1);

  logic                    dv_d;
  logic                    sof;
  logic                    eof;
  logic [CW-1:0]           byte_cnt;
  logic                    byte_ok;
  switch_pkg::port_mask_t  room;
  switch_pkg::port_mask_t  start_mask;
  switch_pkg::port_mask_t  dest_mask;
  switch_pkg::port_mask_t  active_mask;
  switch_pkg::port_mask_t  q_wr_en;
  switch_pkg::queue_word_t q_din;
  logic [QUEUE_AW:0]       q_count [switch_pkg::PORT_COUNT];

  assign sof = rx_dv && !dv_d;
  assign eof = !rx_dv && dv_d;

  // --------------------
  // destination choice
  // --------------------
  always_comb begin
    start_mask = cmd_mode ? fwd_table[PORT_NUM] : '1;
    start_mask = start_mask & room;
    start_mask[PORT_NUM] = 1'b0;
  end

  // mask is live in the first byte cycle, latched after
  assign active_mask = sof ? start_mask : dest_mask;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      dv_d      <= 1'b0;
      byte_cnt  <= '0;
      dest_mask <= '0;
    end else begin
      dv_d <= rx_dv;
      if (sof) begin
        byte_cnt  <= CW'(1);
        dest_mask <= start_mask;
      end else if (rx_dv && byte_ok) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  // bytes past MAX_FRAME are dropped
  assign byte_ok = sof || (byte_cnt < MAX_CNT);

  // --------------------
  // queue writes
  // --------------------
  assign q_din   = rx_dv ? {1'b1, rxd} : '0;
  assign q_wr_en = active_mask & {switch_pkg::PORT_COUNT{(rx_dv && byte_ok) || eof}};

  for (genvar d = 0; d < switch_pkg::PORT_COUNT; d++) begin : g_queue
    assign room[d] = (q_count[d] <= ROOM_LIMIT);

    frame_fifo #(
        .QUEUE_AW(QUEUE_AW)
    ) u_frame_fifo (
        .sys_clk(sys_clk)
      , .reset(reset)
      , .din(q_din)
      , .wr_en(q_wr_en[d])
      , .dout(q_dout[d])
      , .empty(q_empty[d])
      , .rd_en(q_rd_en[d])
      , .data_count(q_count[d])
    );
  end

endmodule

/* tx_mixer.sv */
// tx_mixer module: per-port round-robin frame selection, GMII transmit and gap timing
`timescale 1ns/100ps

module tx_mixer #(
    parameter int IFG = 8
) (
    input  logic sys_clk
  , input  logic reset
  // indexed [source][destination]
  , input  switch_pkg::queue_word_t
           [switch_pkg::PORT_COUNT-1:0][switch_pkg::PORT_COUNT-1:0] q_dout
  , input  switch_pkg::port_mask_t [switch_pkg::PORT_COUNT-1:0] q_empty
  , output switch_pkg::port_mask_t [switch_pkg::PORT_COUNT-1:0] q_rd_en
  , output switch_pkg::gmii_byte_t [switch_pkg::PORT_COUNT-1:0] gmii_txd
  , output switch_pkg::port_mask_t gmii_tx_en
);

  localparam int NP = switch_pkg::PORT_COUNT;
  localparam int GW = (IFG > 1) ? $clog2(IFG) : 1;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_SEND,
    TX_GAP
  } tx_state_t;

  for (genvar t = 0; t < NP; t++) begin : g_tx
    tx_state_t               state;
    switch_pkg::port_idx_t   last_src;
    switch_pkg::port_idx_t   cur_src;
    switch_pkg::port_idx_t   pick_src;
    logic                    pick_valid;
    logic [GW-1:0]           gap_cnt;
    switch_pkg::queue_word_t head;
    logic                    head_avail;
    switch_pkg::gmii_byte_t  txd_r;
    logic                    tx_en_r;

    assign head       = q_dout[cur_src][t];
    assign head_avail = !q_empty[cur_src][t];

    // --------------------
    // round-robin pick
    // --------------------
    // descending scan, so the nearest source after last_src wins
    always_comb begin
      int cand;
      pick_valid = 1'b0;
      pick_src   = last_src;
      for (int k = NP; k >= 1; k--) begin
        cand = (int'(last_src) + k) % NP;
        if (!q_empty[cand][t]) begin
          pick_valid = 1'b1;
          pick_src   = switch_pkg::port_idx_t'(cand);
        end
      end
    end

    // --------------------
    // transmit FSM
    // --------------------
    always_ff @(posedge sys_clk) begin
      if (reset) begin
        state    <= TX_IDLE;
        last_src <= switch_pkg::port_idx_t'(NP - 1);
        cur_src  <= '0;
        gap_cnt  <= '0;
        tx_en_r  <= 1'b0;
      end else begin
        case (state)
          TX_IDLE: begin
            tx_en_r <= 1'b0;
            if (pick_valid) begin
              cur_src  <= pick_src;
              last_src <= pick_src;
              state    <= TX_SEND;
            end
          end
          TX_SEND: begin
            // writer runs ahead, so the queue only runs dry past MAX_FRAME
            tx_en_r <= head_avail && head[8];
            if (head_avail && !head[8]) begin
              gap_cnt <= GW'(IFG - 1);
              state   <= TX_GAP;
            end
          end
          TX_GAP: begin
            tx_en_r <= 1'b0;
            if (gap_cnt == '0) begin
              state <= TX_IDLE;
            end else begin
              gap_cnt <= gap_cnt - 1'b1;
            end
          end
          default: state <= TX_IDLE;
        endcase
      end
    end

    always_ff @(posedge sys_clk) begin
      if (state == TX_SEND && head_avail && head[8]) begin
        txd_r <= head[7:0];
      end
    end

    assign gmii_txd[t]   = txd_r;
    assign gmii_tx_en[t] = tx_en_r;

    // end marker is consumed here too, it just never reaches txd
    for (genvar s = 0; s < NP; s++) begin : g_rd
      assign q_rd_en[s][t] = (state == TX_SEND)
                          && (cur_src == switch_pkg::port_idx_t'(s))
                          && !q_empty[s][t];
    end
  end

endmodule

/* switch_top.sv */
// switch_top module: command receiver, receive port loop and transmit mixers
`timescale 1ns/100ps

module switch_top #(
    parameter int QUEUE_AW  = 8
  , parameter int MAX_FRAME = 64
  , parameter int IFG       = 8
) (
    input  logic sys_clk
  , input  logic reset
  , input  switch_pkg::gmii_byte_t [switch_pkg::PORT_COUNT-1:0] gmii_rxd
  , input  switch_pkg::port_mask_t gmii_rx_dv
  , output switch_pkg::gmii_byte_t [switch_pkg::PORT_COUNT-1:0] gmii_txd
  , output switch_pkg::port_mask_t gmii_tx_en
);

  cmd_pkg::fwd_table_t fwd_table;
  logic                cmd_mode;

  // per source, then per destination
  switch_pkg::queue_word_t
    [switch_pkg::PORT_COUNT-1:0][switch_pkg::PORT_COUNT-1:0] q_dout;
  switch_pkg::port_mask_t [switch_pkg::PORT_COUNT-1:0] q_empty;
  switch_pkg::port_mask_t [switch_pkg::PORT_COUNT-1:0] q_rd_en;

  // --------------------
  // command receiver
  // --------------------
  cmd_recv u_cmd_recv (
      .sys_clk(sys_clk)
    , .reset(reset)
    , .rxd(gmii_rxd[cmd_pkg::CMD_PORT])
    , .rx_dv(gmii_rx_dv[cmd_pkg::CMD_PORT])
    , .fwd_table(fwd_table)
    , .cmd_mode(cmd_mode)
  );

  // --------------------
  // receive ports
  // --------------------
  for (genvar p = 0; p < switch_pkg::PORT_COUNT; p++) begin : g_rx
    rx_port #(
        .PORT_NUM(p)
      , .QUEUE_AW(QUEUE_AW)
      , .MAX_FRAME(MAX_FRAME)
    ) u_rx_port (
        .sys_clk(sys_clk)
      , .reset(reset)
      , .rxd(gmii_rxd[p])
      , .rx_dv(gmii_rx_dv[p])
      , .fwd_table(fwd_table)
      , .cmd_mode(cmd_mode)
      , .q_dout(q_dout[p])
      , .q_empty(q_empty[p])
      , .q_rd_en(q_rd_en[p])
    );
  end

  // --------------------
  // transmit side
  // --------------------
  tx_mixer #(
      .IFG(IFG)
  ) u_tx_mixer (
      .sys_clk(sys_clk)
    , .reset(reset)
    , .q_dout(q_dout)
    , .q_empty(q_empty)
    , .q_rd_en(q_rd_en)
    , .gmii_txd(gmii_txd)
    , .gmii_tx_en(gmii_tx_en)
  );

endmodule

/* tb_switch.sv */
// testbench with stimulus table, clock, reset, transmit monitors and expected frame model
`timescale 1ns/100ps

module tb_switch;

  localparam int NP        = switch_pkg::PORT_COUNT;
  localparam int QUEUE_AW  = 8;
  localparam int MAX_FRAME = 64;
  localparam int IFG       = 8;
  localparam int NROWS     = 18;

  typedef struct {
    int                     src;
    int                     len;
    int                     kind;
    logic [8*NP-1:0]        masks;
    switch_pkg::port_mask_t exp_mask;
    bit                     burst;
  } row_t;

  // kind is 0 for plain, 1 for command and 2 for wrong magic
  // masks holds the mask byte for source k in bits [8k+7:8k]
  row_t rows [NROWS] = '{
    '{1, 20, 0, 32'h0, 4'hD, 1'b0},
    '{0, 16, 0, 32'h0, 4'hE, 1'b0},
    '{3, 12, 0, 32'h0, 4'h7, 1'b0},
    '{2,  9, 0, 32'h0, 4'hB, 1'b0},
    '{3,  8, 1, 32'h030C0BFF, 4'h7, 1'b0},
    '{0, 24, 0, 32'h0, 4'hE, 1'b0},
    '{1, 30, 0, 32'h0, 4'h9, 1'b0},
    '{2, 17, 0, 32'h0, 4'h8, 1'b0},
    '{3, 10, 0, 32'h0, 4'h3, 1'b0},
    '{3, 70, 0, 32'h0, 4'h3, 1'b0},
    '{3,  4, 1, 32'h00010101, 4'h3, 1'b0},
    '{3,  6, 2, 32'h01010101, 4'h3, 1'b0},
    '{0, 15, 0, 32'h0, 4'hE, 1'b0},
    '{2, 11, 0, 32'h0, 4'h8, 1'b0},
    '{1, 14, 0, 32'h0, 4'h9, 1'b0},
    // burst rows all reaching port 3
    '{0, 64, 0, 32'h0, 4'hE, 1'b1},
    '{1, 40, 0, 32'h0, 4'h9, 1'b1},
    '{2, 52, 0, 32'h0, 4'h8, 1'b1}
  };

  logic                            sys_clk;
  logic                            reset;
  switch_pkg::gmii_byte_t [NP-1:0] gmii_rxd;
  switch_pkg::port_mask_t          gmii_rx_dv;
  switch_pkg::gmii_byte_t [NP-1:0] gmii_txd;
  switch_pkg::port_mask_t          gmii_tx_en;

  switch_pkg::gmii_byte_t exp_bytes [NP][$];
  int                     exp_len [NP][$];
  int                     last_src [NP];
  bit                     in_frame [NP];
  bit                     seen_frame [NP];
  int                     run_len [NP];
  int                     gap_len [NP];
  int                     cycles = 0;
  int                     cycle_limit = 0;
  int                     data_errors = 0;
  int                     len_errors = 0;
  int                     gap_errors = 0;
  int                     other_errors = 0;

  switch_top #(
      .QUEUE_AW(QUEUE_AW)
    , .MAX_FRAME(MAX_FRAME)
    , .IFG(IFG)
  ) u_switch_top (
      .sys_clk(sys_clk)
    , .reset(reset)
    , .gmii_rxd(gmii_rxd)
    , .gmii_rx_dv(gmii_rx_dv)
    , .gmii_txd(gmii_txd)
    , .gmii_tx_en(gmii_tx_en)
  );

  initial sys_clk = 1'b0;
  always #4 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, frames did not drain", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // --------------------
  // transmit monitors
  // --------------------
  always @(negedge sys_clk) begin
    switch_pkg::gmii_byte_t exp_b;
    int exp_n;
    if (!reset) begin
      for (int t = 0; t < NP; t++) begin
        if (gmii_tx_en[t]) begin
          if (!in_frame[t] && seen_frame[t] && gap_len[t] < IFG) begin
            $display("gap of %0d cycles on port %0d is below %0d", gap_len[t], t, IFG);
            gap_errors++;
          end
          in_frame[t] = 1'b1;
          run_len[t]++;
          if (exp_bytes[t].size() == 0) begin
            $display("unexpected byte %h on port %0d", gmii_txd[t], t);
            other_errors++;
          end else begin
            exp_b = exp_bytes[t].pop_front();
            if (gmii_txd[t] !== exp_b) begin
              $display("Error: gmii_txd[%0d] expected %h actual %h", t, exp_b, gmii_txd[t]);
              data_errors++;
            end
          end
        end else begin
          if (in_frame[t]) begin
            exp_n = (exp_len[t].size() != 0) ? exp_len[t].pop_front() : 0;
            if (run_len[t] != exp_n) begin
              $display("Error: gmii_tx_en[%0d] frame length expected %h actual %h",
                       t, exp_n, run_len[t]);
              len_errors++;
            end
            in_frame[t]   = 1'b0;
            seen_frame[t] = 1'b1;
            run_len[t]    = 0;
            gap_len[t]    = 0;
          end
          gap_len[t]++;
        end
      end
    end
  end

  function automatic bit all_drained();
    bit ok;
    ok = 1'b1;
    for (int t = 0; t < NP; t++) begin
      if (exp_bytes[t].size() != 0 || in_frame[t]) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  task automatic wait_drain();
    int quiet;
    quiet = 0;
    while (quiet < IFG + 4) begin
      @(posedge sys_clk);
      quiet = all_drained() ? quiet + 1 : 0;
    end
  endtask

  // --------------------
  // frame build and send
  // --------------------
  task automatic send_group(input int first, input int last);
    switch_pkg::gmii_byte_t frame [NP][80];
    int flen [NP];
    int row_of [NP];
    int start;
    int s;
    int n;
    int max_len;
    max_len = 0;
    for (int p = 0; p < NP; p++) begin
      row_of[p] = -1;
      flen[p]   = 0;
    end
    for (int i = first; i <= last; i++) begin
      s         = rows[i].src;
      row_of[s] = i;
      flen[s]   = rows[i].len;
      max_len   = (flen[s] > max_len) ? flen[s] : max_len;
      for (int b = 0; b < flen[s]; b++) begin
        frame[s][b] = 8'($urandom);
      end
      if (rows[i].kind == 0) begin
        frame[s][0] = {4'h5, 4'(s)};
      end else begin
        frame[s][0] = (rows[i].kind == 1) ? cmd_pkg::CMD_MAGIC : 8'h3C;
        for (int k = 1; k <= NP && k < flen[s]; k++) begin
          frame[s][k] = rows[i].masks[8*(k-1) +: 8];
        end
      end
    end
    // round-robin order per transmit port from the source after the last one served
    for (int t = 0; t < NP; t++) begin
      start = last_src[t];
      for (int k = 1; k <= NP; k++) begin
        s = (start + k) % NP;
        if (row_of[s] >= 0) begin
          if (rows[row_of[s]].exp_mask[t]) begin
            n = (flen[s] > MAX_FRAME) ? MAX_FRAME : flen[s];
            for (int b = 0; b < n; b++) begin
              exp_bytes[t].push_back(frame[s][b]);
            end
            exp_len[t].push_back(n);
            last_src[t] = s;
          end
        end
      end
    end
    for (int c = 0; c <= max_len; c++) begin
      @(negedge sys_clk);
      for (int p = 0; p < NP; p++) begin
        gmii_rx_dv[p] = (row_of[p] >= 0 && c < flen[p]);
        gmii_rxd[p]   = gmii_rx_dv[p] ? frame[p][c] : 8'h00;
      end
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int total;
    int i;
    int j;
    void'($urandom(32'h736f_d9ba));
    reset      = 1'b1;
    gmii_rxd   = '0;
    gmii_rx_dv = '0;
    for (int t = 0; t < NP; t++) begin
      last_src[t]   = NP - 1;
      in_frame[t]   = 1'b0;
      seen_frame[t] = 1'b0;
      run_len[t]    = 0;
      gap_len[t]    = 0;
    end
    total = 0;
    for (int r = 0; r < NROWS; r++) begin
      total += rows[r].len;
    end
    cycle_limit = 40 * total + 2000;

    repeat (16) @(posedge sys_clk);
    @(negedge sys_clk);
    reset = 1'b0;
    @(negedge sys_clk);
    if (gmii_tx_en !== '0) begin
      $display("Error: gmii_tx_en expected %h actual %h", 4'h0, gmii_tx_en);
      other_errors++;
    end

    i = 0;
    while (i < NROWS) begin
      j = i;
      if (rows[i].burst) begin
        while (j + 1 < NROWS && rows[j + 1].burst) begin
          j++;
        end
      end
      send_group(i, j);
      wait_drain();
      i = j + 1;
    end
    repeat (50) @(negedge sys_clk);

    $display("errors: data %0d, length %0d, gap %0d, other %0d",
             data_errors, len_errors, gap_errors, other_errors);
    if (data_errors + len_errors + gap_errors + other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* project.f */
switch_pkg.sv
cmd_pkg.sv
frame_fifo.sv
cmd_recv.sv
rx_port.sv
tx_mixer.sv
switch_top.sv
tb_switch.sv

/* run.sh */
#!/bin/sh
# build the switch testbench with Verilator and run it
cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal --top-module tb_switch -f project.f \
       -o tb_switch_sim \
  && ./obj_dir/tb_switch_sim | tee /dev/stderr | grep -qx 'Done: no errors' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
